// File: verilog.f
+incdir+.
fetch_pkg.sv
icache_predecode.sv
icache_array.sv
icache_lookup.sv
target_resolve.sv
icache_fetch.sv
tb_icache_fetch.sv

// File: tb_icache_fetch.sv
/*
  testbench for the instruction fetch cache
  fills directed and random entries, looks them up one cycle later
  and checks instr, miss and target with concurrent assertions
*/

`timescale 1ns/1ns

`include "fetch_cfg.svh"

module tb_icache_fetch;

  import fetch_pkg::*;

  localparam logic [15:0] seed = 16'd29192;
  localparam int n_rand   = 200;
  localparam int n_tests  = n_rand + 8;
  localparam int test_cyc = 24;
  localparam int wd_limit = (10 + n_tests * test_cyc) * 4;

  logic                       clk_i;
  logic                       reset_i;
  logic                       fill_en_i;
  logic [`ICACHE_INDEX_W-1:0] fill_index_i;
  logic [`ICACHE_TAG_W-1:0]   fill_tag_i;
  logic [instr_w-1:0]         fill_instr_i;
  logic [`FETCH_PC_W-1:0]     pc_i;
  logic                       pc_wen_i;
  logic                       flush_i;
  logic [`FETCH_PC_W-1:0]     jalr_pred_i;
  logic [instr_w-1:0]         instr_o;
  logic [`FETCH_PC_W-1:0]     pc_r_o;
  logic [`FETCH_PC_W-1:0]     target_o;
  logic                       miss_o;

  // expected values, and which of them are armed this cycle
  logic [instr_w-1:0]         exp_instr;
  logic                       exp_miss;
  logic [`FETCH_PC_W-1:0]     exp_target;
  logic [`FETCH_PC_W-1:0]     exp_pc;
  logic                       chk_instr;
  logic                       chk_miss;
  logic                       chk_target;

  int                         err_instr = 0;
  int                         err_miss = 0;
  int                         err_target = 0;
  int                         err_pc = 0;
  logic [15:0]                lfsr = seed;
  logic [`ICACHE_TAG_W-1:0]   shadow_tag [int];

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  icache_fetch dut (.*);

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_instr: assert property (@(posedge clk_i) chk_instr |-> instr_o == exp_instr)
    else begin
      err_instr++;
      $display("error at %0t: instr_o expected %h actual %h", $time,
               $sampled(exp_instr), $sampled(instr_o));
    end

  a_miss: assert property (@(posedge clk_i) chk_miss |-> miss_o == exp_miss)
    else begin
      err_miss++;
      $display("error at %0t: miss_o expected %b actual %b", $time,
               $sampled(exp_miss), $sampled(miss_o));
    end

  a_target: assert property (@(posedge clk_i) chk_target |-> target_o == exp_target)
    else begin
      err_target++;
      $display("error at %0t: target_o expected %h actual %h", $time,
               $sampled(exp_target), $sampled(target_o));
    end

  // registered PC follows the last lookup whenever the miss flag is armed
  a_pc_r: assert property (@(posedge clk_i) chk_miss |-> pc_r_o == exp_pc)
    else begin
      err_pc++;
      $display("error at %0t: pc_r_o expected %h actual %h", $time,
               $sampled(exp_pc), $sampled(pc_r_o));
    end

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // fld holds rs2, rs1 and funct3
  function automatic logic [31:0] enc_branch(input logic [12:0] imm, input logic [12:0] fld);
    return {imm[12], imm[10:5], fld, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // word address of byte PC plus byte offset, wrapping at the PC width
  function automatic logic [`FETCH_PC_W-1:0] ref_target(input logic [`FETCH_PC_W-1:0] pc,
                                                         input logic [31:0] off);
    logic [`FETCH_PC_W+1:0] byte_t;
    byte_t = {pc, 2'b00} + off[`FETCH_PC_W+1:0];
    return byte_t[`FETCH_PC_W+1:2];
  endfunction

  // ------------------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------------------
  task automatic fill(input logic [`ICACHE_INDEX_W-1:0] idx,
                      input logic [`ICACHE_TAG_W-1:0] tag, input logic [instr_w-1:0] word);
    @(posedge clk_i);
    fill_en_i    <= 1'b1;
    fill_index_i <= idx;
    fill_tag_i   <= tag;
    fill_instr_i <= word;
    @(posedge clk_i);
    fill_en_i <= 1'b0;
    shadow_tag[idx] = tag;
  endtask

  // arm is {instr, miss, target}, left armed after return so a hold is checked too
  task automatic lookup(input logic [`FETCH_PC_W-1:0] pc, input logic [instr_w-1:0] e_instr,
                        input logic e_miss, input logic [`FETCH_PC_W-1:0] e_target,
                        input logic [`FETCH_PC_W-1:0] jp, input logic [2:0] arm);
    @(posedge clk_i);
    {chk_instr, chk_miss, chk_target} <= 3'b000;
    pc_i        <= pc;
    pc_wen_i    <= 1'b1;
    jalr_pred_i <= jp;
    exp_instr   <= e_instr;
    exp_miss    <= e_miss;
    exp_target  <= e_target;
    exp_pc      <= pc;
    @(posedge clk_i);
    pc_wen_i <= 1'b0;
    {chk_instr, chk_miss, chk_target} <= arm;
    @(posedge clk_i);
  endtask

  task automatic flush_check();
    @(posedge clk_i);
    {chk_instr, chk_miss, chk_target} <= 3'b000;
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i   <= 1'b0;
    exp_instr <= '0;
    chk_instr <= 1'b1;
    repeat (2) @(posedge clk_i);
  endtask

  // fill, hit, optional hold with other fills, then a foreign-tag probe
  task automatic run_case(input logic [1:0] kind, input logic [`ICACHE_INDEX_W-1:0] idx,
                          input logic [`ICACHE_TAG_W-1:0] tag, input logic [20:0] imm,
                          input logic do_hold);
    logic [instr_w-1:0]       word;
    logic [`FETCH_PC_W-1:0]   pc;
    logic [`FETCH_PC_W-1:0]   jp;
    logic [`FETCH_PC_W-1:0]   tgt;
    logic [2:0]               arm;
    logic [`ICACHE_TAG_W-1:0] other_tag;
    pc = {tag, idx};
    jp = rand_bits(`FETCH_PC_W);
    case (kind)
      2'd1: begin
        word = enc_branch(imm[12:0], rand_bits(13));
        tgt  = ref_target(pc, {{19{imm[12]}}, imm[12:0]});
        arm  = 3'b011;
      end
      2'd2: begin
        word = enc_jal(imm, rand_bits(5));
        tgt  = ref_target(pc, {{11{imm[20]}}, imm});
        arm  = 3'b011;
      end
      2'd3: begin
        word = {25'(rand_bits(25)), op_jalr};
        tgt  = jp;
        arm  = 3'b111;
      end
      default: begin
        word = {25'(rand_bits(25)), 7'b0010011};
        tgt  = '0;
        arm  = 3'b110;
      end
    endcase
    fill(idx, tag, word);
    lookup(pc, word, 1'b0, tgt, jp, arm);
    if (do_hold) begin
      for (int i = 1; i <= 3; i++) begin
        fill(idx + i, rand_bits(`ICACHE_TAG_W), rand_bits(instr_w));
      end
    end
    other_tag    = shadow_tag[idx] ^ rand_bits(`ICACHE_TAG_W);
    other_tag[0] = ~shadow_tag[idx][0];
    lookup({other_tag, idx}, '0, 1'b1, '0, jp, 3'b010);
  endtask

  initial begin
    reset_i      <= 1'b1;
    fill_en_i    <= 1'b0;
    fill_index_i <= '0;
    fill_tag_i   <= '0;
    fill_instr_i <= '0;
    pc_i         <= '0;
    pc_wen_i     <= 1'b0;
    flush_i      <= 1'b0;
    jalr_pred_i  <= '0;
    exp_instr    <= '0;
    exp_miss     <= 1'b0;
    exp_target   <= '0;
    exp_pc       <= '0;
    {chk_instr, chk_miss, chk_target} <= 3'b000;
    repeat (10) @(posedge clk_i);
    reset_i   <= 1'b0;
    chk_instr <= 1'b1;
    chk_miss  <= 1'b1;
    repeat (2) @(posedge clk_i);

    // JAL across the 21-bit low part both ways, then PC wrap
    run_case(2'd2, 8'hF0, 14'h07FF, 21'h000400, 1'b0);
    run_case(2'd2, 8'h04, 14'h0800, 21'h1FFF00, 1'b0);
    run_case(2'd2, 8'hFF, 14'h3FFF, 21'h000008, 1'b0);
    // branch across the 13-bit low part
    run_case(2'd1, 8'hFF, 14'h0007, 21'h000020, 1'b0);
    run_case(2'd1, 8'h01, 14'h0008, 21'h001FC0, 1'b0);
    run_case(2'd3, 8'h10, 14'h0123, 21'h000000, 1'b1);
    flush_check();

    for (int t = 0; t < n_rand; t++) begin
      run_case(rand_bits(2), rand_bits(`ICACHE_INDEX_W), rand_bits(`ICACHE_TAG_W),
               rand_bits(21), (t % 16) == 0);
      if ((t % 16) == 8) begin
        flush_check();
      end
    end
    repeat (2) @(posedge clk_i);

    $display("errors: instr_o %0d, miss_o %0d, target_o %0d, pc_r_o %0d",
             err_instr, err_miss, err_target, err_pc);
    if (err_instr + err_miss + err_target + err_pc == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(wd_limit);
    $display("timeout: test sequence did not finish within %0d ns", wd_limit);
    $display("sim failed");
    $finish;
  end

endmodule

// File: icache_fetch.sv
/*
  instruction fetch cache top
  predecoder on the fill side, lookup and target resolver on the read side
*/

`timescale 1ns/1ns

`include "fetch_cfg.svh"

module icache_fetch (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           fill_en_i,
  input  logic [`ICACHE_INDEX_W-1:0]     fill_index_i,
  input  logic [`ICACHE_TAG_W-1:0]       fill_tag_i,
  input  logic [fetch_pkg::instr_w-1:0]  fill_instr_i,
  input  logic [`FETCH_PC_W-1:0]         pc_i,
  input  logic                           pc_wen_i,
  input  logic                           flush_i,
  input  logic [`FETCH_PC_W-1:0]         jalr_pred_i,
  output logic [fetch_pkg::instr_w-1:0]  instr_o,
  output logic [`FETCH_PC_W-1:0]         pc_r_o,
  output logic [`FETCH_PC_W-1:0]         target_o,
  output logic                           miss_o
);

  import fetch_pkg::*;

  logic                       wr_en;
  logic [`ICACHE_INDEX_W-1:0] wr_index;
  icache_entry_t              wr_entry;
  icache_entry_t              held_entry;

  icache_predecode u_predecode (
    .fill_en_i    (fill_en_i),
    .fill_index_i (fill_index_i),
    .fill_tag_i   (fill_tag_i),
    .fill_instr_i (fill_instr_i),
    .wr_en_o      (wr_en),
    .wr_index_o   (wr_index),
    .wr_entry_o   (wr_entry)
  );

  icache_lookup u_lookup (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .wr_en_i      (wr_en),
    .wr_index_i   (wr_index),
    .wr_entry_i   (wr_entry),
    .pc_i         (pc_i),
    .pc_wen_i     (pc_wen_i),
    .flush_i      (flush_i),
    .held_entry_o (held_entry),
    .pc_r_o       (pc_r_o)
  );

  target_resolve u_resolve (
    .held_entry_i (held_entry),
    .pc_r_i       (pc_r_o),
    .jalr_pred_i  (jalr_pred_i),
    .target_o     (target_o),
    .miss_o       (miss_o)
  );

  assign instr_o = held_entry.instr;

endmodule

// File: target_resolve.sv
/*
  jump target resolver
  rebuilds the full word target from the stored low bits and the
  registered PC, and flags a tag miss
*/

`timescale 1ns/1ns

`include "fetch_cfg.svh"

module target_resolve (
  input  fetch_pkg::icache_entry_t     held_entry_i,
  input  logic [`FETCH_PC_W-1:0]       pc_r_i,
  input  logic [`FETCH_PC_W-1:0]       jalr_pred_i,
  output logic [`FETCH_PC_W-1:0]       target_o,
  output logic                         miss_o
);

  import fetch_pkg::*;

  localparam int pc_byte_w = `FETCH_PC_W + 2;
  localparam int b_low_w   = bimm_w + 1;
  localparam int j_low_w   = jimm_w + 1;
  localparam int b_high_w  = pc_byte_w - b_low_w;
  localparam int j_high_w  = pc_byte_w - j_low_w;

  logic                 sel_n1;
  logic                 sel_0;
  logic                 sel_p1;
  logic [b_high_w-1:0]  b_high;
  logic [b_high_w-1:0]  b_high_n1;
  logic [b_high_w-1:0]  b_high_p1;
  logic [b_high_w-1:0]  b_high_out;
  logic [j_high_w-1:0]  j_high;
  logic [j_high_w-1:0]  j_high_n1;
  logic [j_high_w-1:0]  j_high_p1;
  logic [j_high_w-1:0]  j_high_out;
  logic [pc_byte_w-1:0] b_target;
  logic [pc_byte_w-1:0] j_target;
  logic                 is_jal;
  logic                 is_jalr;

  // ------------------------------------------------------------
  // high-part select from sign and carry
  // ------------------------------------------------------------
  // equal bits leave the high part alone
  assign sel_0  = ~(held_entry_i.lower_sign ^ held_entry_i.lower_cout);
  assign sel_p1 = ~held_entry_i.lower_sign & held_entry_i.lower_cout;
  assign sel_n1 = held_entry_i.lower_sign & ~held_entry_i.lower_cout;

  // byte PC is {pc_r, 2'b00}, so shift the slice down by two
  assign b_high    = pc_r_i[(b_low_w-2) +: b_high_w];
  assign b_high_n1 = b_high - 1'b1;
  assign b_high_p1 = b_high + 1'b1;
  assign b_high_out = ({b_high_w{sel_n1}} & b_high_n1) |
                      ({b_high_w{sel_0}}  & b_high)    |
                      ({b_high_w{sel_p1}} & b_high_p1);

  assign j_high    = pc_r_i[(j_low_w-2) +: j_high_w];
  assign j_high_n1 = j_high - 1'b1;
  assign j_high_p1 = j_high + 1'b1;
  assign j_high_out = ({j_high_w{sel_n1}} & j_high_n1) |
                      ({j_high_w{sel_0}}  & j_high)    |
                      ({j_high_w{sel_p1}} & j_high_p1);

  // byte targets, low parts already summed at fill time
  assign b_target = {b_high_out, bimm13_extract(held_entry_i.instr)};
  assign j_target = {j_high_out, jimm21_extract(held_entry_i.instr)};

  assign is_jal  = (held_entry_i.instr[6:0] == op_jal);
  assign is_jalr = (held_entry_i.instr[6:0] == op_jalr);

  // word address out
  assign target_o = is_jal  ? j_target[2 +: `FETCH_PC_W] :
                    is_jalr ? jalr_pred_i :
                              b_target[2 +: `FETCH_PC_W];

  assign miss_o = (held_entry_i.tag != pc_r_i[`ICACHE_INDEX_W +: `ICACHE_TAG_W]);

endmodule

// File: icache_lookup.sv
/*
  icache lookup side
  picks the array address, registers the PC and holds or flushes
  the entry that was read while the PC is not written
*/

`timescale 1ns/1ns

`include "fetch_cfg.svh"

module icache_lookup (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         wr_en_i,
  input  logic [`ICACHE_INDEX_W-1:0]   wr_index_i,
  input  fetch_pkg::icache_entry_t     wr_entry_i,
  input  logic [`FETCH_PC_W-1:0]       pc_i,
  input  logic                         pc_wen_i,
  input  logic                         flush_i,
  output fetch_pkg::icache_entry_t     held_entry_o,
  output logic [`FETCH_PC_W-1:0]       pc_r_o
);

  import fetch_pkg::*;

  logic                       arr_en;
  logic [`ICACHE_INDEX_W-1:0] arr_addr;
  icache_entry_t              rd_entry;
  icache_entry_t              held_r;
  logic [`FETCH_PC_W-1:0]     pc_r;
  logic                       pc_wen_r;

  // fill wins the address
  assign arr_en   = wr_en_i | pc_wen_i;
  assign arr_addr = wr_en_i ? wr_index_i : pc_i[`ICACHE_INDEX_W-1:0];

  icache_array u_array (
    .clk_i   (clk_i),
    .en_i    (arr_en),
    .wen_i   (wr_en_i),
    .addr_i  (arr_addr),
    .wdata_i (wr_entry_i),
    .rdata_o (rd_entry)
  );

  // ------------------------------------------------------------
  // PC register and held entry
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_r     <= '0;
      pc_wen_r <= 1'b0;
      held_r   <= '0;
    end else begin
      pc_wen_r <= pc_wen_i;
      if (pc_wen_i) begin
        pc_r <= pc_i;
      end
      held_r <= flush_i ? '0 : held_entry_o;
    end
  end

  // fresh read only right after a PC write, else the held copy
  assign held_entry_o = pc_wen_r ? rd_entry : held_r;
  assign pc_r_o       = pc_r;

  // a lookup in a fill cycle reads whatever the write left behind
  a_no_fill_lookup: assert property (@(posedge clk_i) disable iff (reset_i)
    !(wr_en_i && pc_wen_i))
    else $error("pc_wen_i in a fill cycle, lookup result undefined");

endmodule

// File: icache_array.sv
/*
  icache entry memory
  single-port synchronous RAM, one read or one write per cycle
*/

`timescale 1ns/1ns

`include "fetch_cfg.svh"

module icache_array (
  input  logic                         clk_i,
  input  logic                         en_i,
  input  logic                         wen_i,
  input  logic [`ICACHE_INDEX_W-1:0]   addr_i,
  input  fetch_pkg::icache_entry_t     wdata_i,
  output fetch_pkg::icache_entry_t     rdata_o
);

  import fetch_pkg::*;

  localparam int depth = 2 ** `ICACHE_INDEX_W;

  // contents undefined until the loader writes them
  icache_entry_t mem [depth];

  // ------------------------------------------------------------
  // read data lands one edge after the request
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (wen_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: icache_predecode.sv
/*
  icache fill-side predecoder
  adds branch and JAL immediates to the low bits of the fill PC and
  writes the sum back into the word, with sign and carry kept beside it
*/

`timescale 1ns/1ns

`include "fetch_cfg.svh"

module icache_predecode (
  input  logic                           fill_en_i,
  input  logic [`ICACHE_INDEX_W-1:0]     fill_index_i,
  input  logic [`ICACHE_TAG_W-1:0]       fill_tag_i,
  input  logic [fetch_pkg::instr_w-1:0]  fill_instr_i,
  output logic                           wr_en_o,
  output logic [`ICACHE_INDEX_W-1:0]     wr_index_o,
  output fetch_pkg::icache_entry_t       wr_entry_o
);

  import fetch_pkg::*;

  logic                  is_branch;
  logic                  is_jal;
  logic [`FETCH_PC_W+1:0] fill_pc_byte;
  logic [bimm_w:0]       b_imm;
  logic [bimm_w:0]       b_pc_low;
  logic [bimm_w:0]       b_sum;
  logic                  b_cout;
  logic [jimm_w:0]       j_imm;
  logic [jimm_w:0]       j_pc_low;
  logic [jimm_w:0]       j_sum;
  logic                  j_cout;
  logic [instr_w-1:0]    injected;
  logic                  imm_sign;
  logic                  low_cout;

  assign is_branch = (fill_instr_i[6:0] == op_branch);
  assign is_jal    = (fill_instr_i[6:0] == op_jal);

  // ------------------------------------------------------------
  // low-part adders on the byte PC
  // ------------------------------------------------------------
  assign fill_pc_byte = {fill_tag_i, fill_index_i, 2'b00};

  assign b_imm    = bimm13_extract(fill_instr_i);
  assign b_pc_low = fill_pc_byte[bimm_w:0];
  assign {b_cout, b_sum} = {1'b0, b_imm} + {1'b0, b_pc_low};

  assign j_imm    = jimm21_extract(fill_instr_i);
  assign j_pc_low = fill_pc_byte[jimm_w:0];
  assign {j_cout, j_sum} = {1'b0, j_imm} + {1'b0, j_pc_low};

  // sum bit 0 is always zero, so only bits above it go back in
  always_comb begin
    injected = fill_instr_i;
    if (is_branch) begin
      injected[31]    = b_sum[12];
      injected[7]     = b_sum[11];
      injected[30:25] = b_sum[10:5];
      injected[11:8]  = b_sum[4:1];
    end else if (is_jal) begin
      injected[31]    = j_sum[20];
      injected[19:12] = j_sum[19:12];
      injected[20]    = j_sum[11];
      injected[30:21] = j_sum[10:1];
    end
  end

  // high-part fix-up bits, zero for everything else
  assign imm_sign = is_branch ? b_imm[bimm_w] : (is_jal & j_imm[jimm_w]);
  assign low_cout = is_branch ? b_cout : (is_jal & j_cout);

  assign wr_en_o    = fill_en_i;
  assign wr_index_o = fill_index_i;
  assign wr_entry_o = '{lower_sign: imm_sign,
                        lower_cout: low_cout,
                        tag:        fill_tag_i,
                        instr:      injected};

endmodule

// File: fetch_pkg.sv
/*
  fetch package
  RV32 instruction constants, immediate widths, immediate extraction
  and the stored cache entry format
*/

`include "fetch_cfg.svh"

package fetch_pkg;

  localparam int instr_w = 32;

  // major opcodes, instr[6:0]
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;

  // immediate widths without bit 0, low adders are one bit wider
  localparam int bimm_w = 12;
  localparam int jimm_w = 20;

  // one cache entry, instr carries the injected target low bits
  typedef struct packed {
    logic                     lower_sign;
    logic                     lower_cout;
    logic [`ICACHE_TAG_W-1:0] tag;
    logic [instr_w-1:0]       instr;
  } icache_entry_t;

  // 13-bit byte offset of a B-type word
  function automatic logic [bimm_w:0] bimm13_extract(input logic [instr_w-1:0] instr);
    return {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  endfunction

  // 21-bit byte offset of a J-type word
  function automatic logic [jimm_w:0] jimm21_extract(input logic [instr_w-1:0] instr);
    return {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

endpackage

// File: fetch_cfg.svh
/*
  fetch cache configuration
  tag, index and word PC widths shared by the package, the RTL and the testbench
*/

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// tag bits of the word PC
`define ICACHE_TAG_W 14

// index bits, 2**ICACHE_INDEX_W entries
`define ICACHE_INDEX_W 8

// word PC is tag plus index
`define FETCH_PC_W (`ICACHE_TAG_W + `ICACHE_INDEX_W)

`endif
